//--- src/alu_core_pkg.sv
// Shared types for the RV32I integer core: words, instruction layouts,
// decoded operations and the stream items passed between the stages.

package alu_core_pkg;

    // Data word and register index
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    //////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////

    // Major opcodes kept in this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // ALU function, lui runs through ALU_ADD
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_type_t;

    // Immediate layout
    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_type_t;

    // Upper-immediate layout
    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        opcode_e     opcode;
    } u_type_t;

    // Same 32-bit word seen through each format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } inst_u;

    //////////////////////////////////////////////////
    // Pipeline items
    //////////////////////////////////////////////////

    // Decoder output
    typedef struct packed {
        alu_op_e   op;
        logic      use_imm;   // operand b is the immediate
        logic      zero_a;    // operand a forced to zero
        word_t     imm;
        reg_addr_t rd;
        logic      write;
        logic      illegal;
    } decoded_t;

    // Issue register contents
    typedef struct packed {
        alu_op_e   op;
        word_t     a;
        word_t     b;
        reg_addr_t rd;
        logic      write;
        logic      illegal;
    } issue_t;

    // One output item
    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
        logic      illegal;
    } result_t;

    // Register bank write port
    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } writeback_t;

endpackage

//--- src/inst_decoder.sv
// Combinational RV32I decoder for OP, OP-IMM and LUI words.
// Produces the ALU function, the placed immediate and the destination.

module inst_decoder
    import alu_core_pkg::*;
(
    input  inst_u    inst_i,
    output decoded_t decoded_o
);

    always_comb begin
        // Defaults: register operands, add, rd from the common field
        decoded_o.op      = ALU_ADD;
        decoded_o.use_imm = 1'b0;
        decoded_o.zero_a  = 1'b0;
        decoded_o.imm     = '0;
        decoded_o.rd      = inst_i.r.rd;
        decoded_o.illegal = 1'b0;

        case (inst_i.r.opcode)
            //////////////////////////////////////////////////
            // Register-register
            //////////////////////////////////////////////////
            OPC_OP: begin
                case ({inst_i.r.funct7, inst_i.r.funct3})
                    {7'h00, 3'h0}: decoded_o.op = ALU_ADD;
                    {7'h20, 3'h0}: decoded_o.op = ALU_SUB;
                    {7'h00, 3'h1}: decoded_o.op = ALU_SLL;
                    {7'h00, 3'h2}: decoded_o.op = ALU_SLT;
                    {7'h00, 3'h3}: decoded_o.op = ALU_SLTU;
                    {7'h00, 3'h4}: decoded_o.op = ALU_XOR;
                    {7'h00, 3'h5}: decoded_o.op = ALU_SRL;
                    {7'h20, 3'h5}: decoded_o.op = ALU_SRA;
                    {7'h00, 3'h6}: decoded_o.op = ALU_OR;
                    {7'h00, 3'h7}: decoded_o.op = ALU_AND;
                    default:       decoded_o.illegal = 1'b1;
                endcase
            end
            //////////////////////////////////////////////////
            // Register-immediate
            //////////////////////////////////////////////////
            OPC_OP_IMM: begin
                decoded_o.use_imm = 1'b1;
                // Sign-extend the 12-bit immediate
                decoded_o.imm     = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
                case (inst_i.i.funct3)
                    3'h0: decoded_o.op = ALU_ADD;
                    3'h2: decoded_o.op = ALU_SLT;
                    3'h3: decoded_o.op = ALU_SLTU;
                    3'h4: decoded_o.op = ALU_XOR;
                    3'h6: decoded_o.op = ALU_OR;
                    3'h7: decoded_o.op = ALU_AND;
                    // Shifts need a clean upper field
                    3'h1: begin
                        decoded_o.op      = ALU_SLL;
                        decoded_o.illegal = (inst_i.i.imm[11:5] != 7'h00);
                    end
                    3'h5: begin
                        decoded_o.op      = inst_i.i.imm[10] ? ALU_SRA : ALU_SRL;
                        decoded_o.illegal = ({inst_i.i.imm[11], inst_i.i.imm[9:5]} != 6'h00);
                    end
                    default: decoded_o.illegal = 1'b1;
                endcase
            end
            // lui is 0 + (imm << 12)
            OPC_LUI: begin
                decoded_o.use_imm = 1'b1;
                decoded_o.zero_a  = 1'b1;
                decoded_o.imm     = {inst_i.u.imm, 12'h000};
            end
            default: decoded_o.illegal = 1'b1;
        endcase

        // Illegal words never write
        decoded_o.write = !decoded_o.illegal;
    end

endmodule

//--- src/reg_bank.sv
// Integer register file x1..x31 with two combinational read ports.
// A read of the register written this cycle returns the write data.

module reg_bank
    import alu_core_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  reg_addr_t  rs1_i,
    input  reg_addr_t  rs2_i,
    input  writeback_t wb_i,
    output word_t      rs1_data_o,
    output word_t      rs2_data_o
);

    // x0 has no storage
    word_t regs [1:31];

    // Write is live only for a nonzero destination
    logic  wr_live;

    assign wr_live = wb_i.en && (wb_i.rd != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // One read port: x0, write-through, or stored value
    function automatic word_t read_port(reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_live && (addr == wb_i.rd)) begin
            value = wb_i.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

//--- src/issue_stage.sv
// Issue register between decode/register read and execute.
// Selects the operands and runs the input valid/ready handshake.

module issue_stage
    import alu_core_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,

    // Instruction stream side
    input  logic     inst_valid_i,
    output logic     inst_ready_o,
    input  decoded_t decoded_i,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,

    // Toward execute
    output logic     issue_valid_o,
    output issue_t   issue_o,
    input  logic     issue_ready_i
);

    logic   valid_q;
    issue_t issue_q;
    issue_t issue_d;
    logic   accept;

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    // Free when empty or drained this cycle
    assign inst_ready_o = !valid_q || issue_ready_i;
    assign accept       = inst_valid_i && inst_ready_o;

    //////////////////////////////////////////////////
    // Operand select
    //////////////////////////////////////////////////

    always_comb begin
        issue_d.op      = decoded_i.op;
        // Zero for lui, else rs1
        issue_d.a       = decoded_i.zero_a ? '0 : rs1_data_i;
        // Immediate forms take imm in place of rs2
        issue_d.b       = decoded_i.use_imm ? decoded_i.imm : rs2_data_i;
        issue_d.rd      = decoded_i.rd;
        issue_d.write   = decoded_i.write;
        issue_d.illegal = decoded_i.illegal;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (inst_ready_o) begin
            valid_q <= inst_valid_i;
        end
    end

    // Payload loads only on transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_q <= issue_d;
        end
    end

    assign issue_valid_o = valid_q;
    assign issue_o       = issue_q;

endmodule

//--- src/execute_unit.sv
// Integer ALU stage with the result register and the write-back port.
// A register write happens on the edge that accepts an issued item.

module execute_unit
    import alu_core_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,

    // From issue
    input  logic       issue_valid_i,
    input  issue_t     issue_i,
    output logic       issue_ready_o,

    // Result stream
    output logic       result_valid_o,
    output result_t    result_o,
    input  logic       result_ready_i,

    // To register bank
    output writeback_t wb_o
);

    logic       valid_q;
    result_t    result_q;
    logic       take;
    logic [4:0] shamt;
    word_t      alu_res;

    // Result register free or being drained
    assign issue_ready_o = !valid_q || result_ready_i;
    assign take          = issue_valid_i && issue_ready_o;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    // Shifts use the low five bits only
    assign shamt = issue_i.b[4:0];

    always_comb begin
        case (issue_i.op)
            ALU_ADD:  alu_res = issue_i.a + issue_i.b;
            ALU_SUB:  alu_res = issue_i.a - issue_i.b;
            ALU_SLL:  alu_res = issue_i.a << shamt;
            ALU_SLT:  alu_res = {31'b0, $signed(issue_i.a) < $signed(issue_i.b)};
            ALU_SLTU: alu_res = {31'b0, issue_i.a < issue_i.b};
            ALU_XOR:  alu_res = issue_i.a ^ issue_i.b;
            ALU_SRL:  alu_res = issue_i.a >> shamt;
            ALU_SRA:  alu_res = $signed(issue_i.a) >>> shamt;
            ALU_OR:   alu_res = issue_i.a | issue_i.b;
            ALU_AND:  alu_res = issue_i.a & issue_i.b;
            default:  alu_res = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Result register and write-back
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (issue_ready_o) begin
            valid_q <= issue_valid_i;
        end
    end

    // Illegal items report zero data
    always_ff @(posedge clk) begin
        if (take) begin
            result_q.rd      <= issue_i.rd;
            result_q.data    <= issue_i.illegal ? '0 : alu_res;
            result_q.illegal <= issue_i.illegal;
        end
    end

    assign result_valid_o = valid_q;
    assign result_o       = result_q;

    // Bank drops x0 writes itself
    assign wb_o.en   = take && issue_i.write;
    assign wb_o.rd   = issue_i.rd;
    assign wb_o.data = alu_res;

endmodule

//--- src/alu_core.sv
// Top of the RV32I integer core: instruction stream in, result stream out.
// Decode and register read run side by side ahead of issue and execute.

module alu_core
    import alu_core_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,

    // Instruction stream
    input  logic    inst_valid_i,
    output logic    inst_ready_o,
    input  inst_u   inst_i,

    // Result stream
    output logic    result_valid_o,
    input  logic    result_ready_i,
    output result_t result_o
);

    decoded_t   decoded;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       issue_valid;
    logic       issue_ready;
    issue_t     issue;
    writeback_t wb;

    //////////////////////////////////////////////////
    // Decode and register read
    //////////////////////////////////////////////////

    inst_decoder inst_decoder_i (
        .inst_i    (inst_i),
        .decoded_o (decoded)
    );

    // Source fields sit at the same place in every format
    reg_bank reg_bank_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_i      (inst_i.r.rs1),
        .rs2_i      (inst_i.r.rs2),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    //////////////////////////////////////////////////
    // Issue and execute
    //////////////////////////////////////////////////

    issue_stage issue_stage_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_valid_i  (inst_valid_i),
        .inst_ready_o  (inst_ready_o),
        .decoded_i     (decoded),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .issue_valid_o (issue_valid),
        .issue_o       (issue),
        .issue_ready_i (issue_ready)
    );

    execute_unit execute_unit_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .issue_valid_i  (issue_valid),
        .issue_i        (issue),
        .issue_ready_o  (issue_ready),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_ready_i (result_ready_i),
        .wb_o           (wb)
    );

endmodule

//--- sim/tb_alu_core_ref.svh
// Reference model of the integer core for the testbench: shadow registers,
// instruction encoders and the result compare. Included inside tb_alu_core.

`ifndef TB_ALU_CORE_REF_SVH
`define TB_ALU_CORE_REF_SVH

    // Architectural state as the ISA defines it, x0 stays zero
    word_t shadow [32] = '{default: '0};

    //////////////////////////////////////////////////
    // Encoders
    //////////////////////////////////////////////////

    function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                    reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                    logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t enc_u(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    //////////////////////////////////////////////////
    // ISA semantics
    //////////////////////////////////////////////////

    // Function selected by funct3, alt picks sub or sra
    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        word_t v;
        case (f3)
            3'h0: v = alt ? a - b : a + b;
            3'h1: v = a << b[4:0];
            3'h2: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'h3: v = (a < b) ? 32'd1 : 32'd0;
            3'h4: v = a ^ b;
            3'h5: begin
                // Kept apart so the arithmetic shift stays signed
                if (alt) begin
                    v = $signed(a) >>> b[4:0];
                end else begin
                    v = a >> b[4:0];
                end
            end
            3'h6: v = a | b;
            default: v = a & b;
        endcase
        return v;
    endfunction

    // Expected output item for one word, in issue order
    function automatic result_t ref_model(word_t w);
        result_t    res;
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        logic       ok;
        opc      = w[6:0];
        f7       = w[31:25];
        f3       = w[14:12];
        a        = shadow[w[19:15]];
        b        = shadow[w[24:20]];
        res.rd   = w[11:7];
        res.data = '0;
        ok       = 1'b0;
        if (opc == 7'b0110011) begin
            // funct7 bit 5 only for sub and sra
            ok       = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'h0) || (f3 == 3'h5)));
            res.data = alu_ref(f3, f7[5], a, b);
        end else if (opc == 7'b0010011) begin
            b = {{20{w[31]}}, w[31:20]};
            if (f3 == 3'h1) begin
                ok = (f7 == 7'h00);
            end else if (f3 == 3'h5) begin
                ok = (f7 == 7'h00) || (f7 == 7'h20);
            end else begin
                ok = 1'b1;
            end
            // addi never subtracts
            res.data = alu_ref(f3, (f3 == 3'h5) && f7[5], a, b);
        end else if (opc == 7'b0110111) begin
            ok       = 1'b1;
            res.data = {w[31:12], 12'h000};
        end
        if (!ok) begin
            res.data = '0;
        end
        res.illegal = !ok;
        if (ok && (res.rd != 5'd0)) begin
            shadow[res.rd] = res.data;
        end
        return res;
    endfunction

    //////////////////////////////////////////////////
    // Compare
    //////////////////////////////////////////////////

    task automatic check_result(result_t got, result_t exp);
        if (got.rd !== exp.rd) begin
            $display("ERR result_o.rd got %h exp %h", got.rd, exp.rd);
            err_cnt++;
        end
        if (got.data !== exp.data) begin
            $display("ERR result_o.data got %h exp %h", got.data, exp.data);
            err_cnt++;
        end
        if (got.illegal !== exp.illegal) begin
            $display("ERR result_o.illegal got %h exp %h", got.illegal, exp.illegal);
            err_cnt++;
        end
    endtask

`endif

//--- sim/tb_alu_core.sv
// Testbench for the integer core: drives instruction words, collects the
// result stream and checks every item against the reference model.

module tb_alu_core
    import alu_core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic    clk;
    logic    reset_i;
    logic    inst_valid_i;
    logic    inst_ready_o;
    inst_u   inst_i;
    logic    result_valid_o;
    logic    result_ready_i;
    result_t result_o;

    // Expected items in issue order
    result_t exp_q [$];
    int      err_cnt  = 0;
    int      err_mark = 0;
    int      test_num = 0;
    int      sent_cnt = 0;
    int      recv_cnt = 0;
    logic    bp_on    = 1'b0;
    word_t   stim_state = 32'h3074;
    word_t   bp_state   = 32'h3074;

    `include "tb_alu_core_ref.svh"

    alu_core alu_core_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .inst_valid_i   (inst_valid_i),
        .inst_ready_o   (inst_ready_o),
        .inst_i         (inst_i),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_o       (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic word_t lcg_next(inout word_t state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    // Random OP, OP-IMM or LUI word, high LCG bits only
    function automatic word_t rand_legal();
        word_t       r;
        word_t       s;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        r   = lcg_next(stim_state);
        s   = lcg_next(stim_state);
        f3  = r[16:14];
        imm = s[31:20];
        alt = r[11] && ((f3 == 3'h0) || (f3 == 3'h5));
        if (r[13:12] == 2'd1) begin
            if (f3 == 3'h1) begin
                imm[11:5] = 7'h00;
            end else if (f3 == 3'h5) begin
                imm[11:5] = r[11] ? 7'h20 : 7'h00;
            end
            return enc_i(f3, r[31:27], r[26:22], imm);
        end else if (r[13:12] == 2'd2) begin
            return enc_u(r[31:27], s[31:12]);
        end
        return enc_r(alt ? 7'h20 : 7'h00, f3, r[31:27], r[26:22], r[21:17]);
    endfunction

    // Load, branch, M-extension and bad slli shapes
    function automatic word_t rand_illegal();
        word_t w;
        word_t sel;
        w   = lcg_next(stim_state);
        sel = lcg_next(stim_state);
        case (sel[31:30])
            2'd0: w[6:0] = 7'b0000011;
            2'd1: w[6:0] = 7'b1100011;
            2'd2: w = {7'h01, w[24:7], OPC_OP};
            default: w = {7'h10, w[24:15], 3'h1, w[11:7], OPC_OP_IMM};
        endcase
        return w;
    endfunction

    task automatic abort(string why);
        $display("Timeout: %s", why);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Called on a rising edge, returns on the transfer edge
    task automatic send(word_t w);
        int waited;
        exp_q.push_back(ref_model(w));
        inst_valid_i <= 1'b1;
        inst_i       <= w;
        waited = 0;
        @(negedge clk);
        while (!inst_ready_o && (waited < 100)) begin
            waited++;
            @(negedge clk);
        end
        if (!inst_ready_o) begin
            abort("inst_ready_o stayed low while an instruction was offered");
        end else begin
            // No stall while the result stream is always ready
            if (!bp_on && (waited != 0)) begin
                $display("inst_ready_o dropped while the result stream was always ready");
                err_cnt++;
            end
            @(posedge clk);
            sent_cnt++;
        end
    endtask

    task automatic finish_test(string name);
        int waited;
        inst_valid_i <= 1'b0;
        waited = 0;
        while ((exp_q.size() != 0) && (waited < 1000)) begin
            waited++;
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            abort("expected results never arrived on the result stream");
        end else begin
            // Quiet cycles to catch extra items
            repeat (4) @(posedge clk);
            if (recv_cnt != sent_cnt) begin
                $display("Result count %0d does not match instruction count %0d",
                         recv_cnt, sent_cnt);
                err_cnt++;
            end
            test_num++;
            $display("test %0d %s %s (%0d errors)", test_num, name,
                     (err_cnt == err_mark) ? "ok" : "failed", err_cnt - err_mark);
            err_mark = err_cnt;
        end
    endtask

    //////////////////////////////////////////////////
    // Collector and ready driver
    //////////////////////////////////////////////////

    initial begin : collector
        word_t   rnd;
        result_t exp;
        forever begin
            @(posedge clk);
            rnd = lcg_next(bp_state);
            result_ready_i <= bp_on ? rnd[31] : 1'b1;
            // Inputs settle between edges
            @(negedge clk);
            if (!reset_i && result_valid_o && result_ready_i) begin
                recv_cnt++;
                if (exp_q.size() == 0) begin
                    $display("Result item for rd %0d arrived with nothing expected",
                             result_o.rd);
                    err_cnt++;
                end else begin
                    exp = exp_q.pop_front();
                    check_result(result_o, exp);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        word_t     w;
        reg_addr_t tgt;
        reset_i        = 1'b1;
        inst_valid_i   = 1'b0;
        inst_i         = '0;
        result_ready_i = 1'b1;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);

        // Reset state, all registers zero
        @(negedge clk);
        check_flag("result_valid_o", result_valid_o, 1'b0);
        check_flag("inst_ready_o", inst_ready_o, 1'b1);
        @(posedge clk);
        send(enc_r(7'h00, 3'h0, 5'd5, 5'd1, 5'd2));
        finish_test("reset");

        // Each word reads the previous rd, back to back
        send(enc_i(3'h0, 5'd1, 5'd0, 12'd7));
        for (int k = 1; k < 13; k++) begin
            case (k % 4)
                0: w = enc_r(7'h00, 3'h0, reg_addr_t'(k + 1), reg_addr_t'(k), reg_addr_t'(k));
                1: w = enc_i(3'h4, reg_addr_t'(k + 1), reg_addr_t'(k), 12'h5a5);
                2: w = enc_i(3'h1, reg_addr_t'(k + 1), reg_addr_t'(k), 12'd3);
                default: w = enc_r(7'h20, 3'h0, reg_addr_t'(k + 1), reg_addr_t'(k), 5'd1);
            endcase
            send(w);
        end
        finish_test("chain");

        for (int n = 0; n < 200; n++) begin
            send(rand_legal());
        end
        finish_test("random");

        // x0 results show up but never land
        send(enc_i(3'h0, 5'd0, 5'd0, 12'h123));
        send(enc_u(5'd0, 20'habcde));
        send(enc_r(7'h00, 3'h6, 5'd6, 5'd0, 5'd0));
        send(enc_i(3'h0, 5'd7, 5'd0, 12'h000));
        finish_test("x0");

        // Illegal word, then copy its target onto itself
        for (int n = 0; n < 20; n++) begin
            w   = rand_illegal();
            tgt = w[11:7];
            send(w);
            send(enc_r(7'h00, 3'h6, tgt, tgt, 5'd0));
        end
        finish_test("illegal");

        bp_on = 1'b1;
        for (int n = 0; n < 150; n++) begin
            send(rand_legal());
        end
        finish_test("backpressure");

        $display("tests %0d, instructions %0d, results %0d, errors %0d",
                 test_num, sent_cnt, recv_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+sim
src/alu_core_pkg.sv
src/inst_decoder.sv
src/reg_bank.sv
src/issue_stage.sv
src/execute_unit.sv
src/alu_core.sv
sim/tb_alu_core.sv

//--- Bender.yml
package:
  name: alu_core

sources:
  - files:
      - src/alu_core_pkg.sv
      - src/inst_decoder.sv
      - src/reg_bank.sv
      - src/issue_stage.sv
      - src/execute_unit.sv
      - src/alu_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_alu_core.sv
